/* common/btc_dec_pkg.sv */
`default_nettype none

package btc_dec_pkg;

  //--------------------------------------------------
  // soft value widths
  //--------------------------------------------------

  // channel soft value
  localparam int cLLR_W  = 4;
  // extrinsic value
  localparam int cEXTR_W = 5;

  // saturation range of the extrinsic
  localparam int cEXTR_MAX = 2**(cEXTR_W-1) - 1;
  localparam int cEXTR_MIN = -(2**(cEXTR_W-1));

  // internal width for signed llr + extrinsic arithmetic
  localparam int cSAT_W = ((cLLR_W > cEXTR_W) ? cLLR_W : cEXTR_W) + 2;

  //--------------------------------------------------
  // types
  //--------------------------------------------------

  // negative means bit 1
  typedef logic signed [cLLR_W-1 : 0]  llr_t;
  typedef logic signed [cEXTR_W-1 : 0] extr_t;
  // unsigned magnitude of llr_t, -max still fits
  typedef logic        [cLLR_W-1 : 0]  mag_t;

  // word strobes
  typedef logic [2 : 0] strb_t;

  // first word of codeword, of frame when on lane 0
  localparam int cSTRB_SOF  = 0;
  // last word of codeword
  localparam int cSTRB_EOF  = 1;
  // filler bit, not counted as error
  localparam int cSTRB_MASK = 2;

endpackage

`default_nettype wire

/* comp_code/btc_dec_comp_code_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module btc_dec_comp_code_lane import btc_dec_pkg::*; #(
  parameter int pDEC_NUM = 8
) (
  input  wire logic  iclk,
  input  wire logic  ireset,
  input  wire logic  iclkena,
  input  wire logic  ival,
  input  wire strb_t istrb,
  input  wire llr_t  illr,
  output logic       oval,
  output strb_t      ostrb,
  output extr_t      oextr,
  output logic       obitdat,
  output logic       obiterr
);

  localparam int cIDX_W = (pDEC_NUM > 1) ? $clog2(pDEC_NUM) : 1;

  typedef logic [cIDX_W-1 : 0] idx_t;

  //--------------------------------------------------
  // input side, buffer write and min tracking
  //--------------------------------------------------

  // ping-pong codeword buffer, two halves
  llr_t  llr_buf  [2][pDEC_NUM];
  strb_t strb_buf [2][pDEC_NUM];

  logic in_sof, in_eof, in_sign;
  mag_t in_mag;
  idx_t wr_cnt, wr_idx;
  logic wr_half, rd_half;

  // running min-sum state of the loading codeword
  mag_t run_min1, run_min2, nxt_min1, nxt_min2;
  idx_t run_idx, nxt_idx;
  logic run_par, nxt_par;

  // frozen state of the draining codeword
  mag_t dr_min1, dr_min2;
  idx_t dr_idx;
  logic dr_par;
  logic drain_act;
  idx_t drain_cnt;

  always_comb begin
    in_sof  = istrb[cSTRB_SOF];
    in_eof  = istrb[cSTRB_EOF];
    wr_idx  = in_sof ? '0 : wr_cnt;
    in_sign = illr[cLLR_W-1];
    in_mag  = in_sign ? mag_t'(-illr) : mag_t'(illr);
    // first word seeds the search
    if (in_sof) begin
      nxt_min1 = in_mag;
      nxt_min2 = '1;
      nxt_idx  = '0;
      nxt_par  = in_sign;
    end else begin
      nxt_min1 = run_min1;
      nxt_min2 = run_min2;
      nxt_idx  = run_idx;
      nxt_par  = run_par ^ in_sign;
      if (in_mag < run_min1) begin
        nxt_min2 = run_min1;
        nxt_min1 = in_mag;
        nxt_idx  = wr_idx;
      end else if (in_mag < run_min2) begin
        nxt_min2 = in_mag;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      llr_buf[wr_half][wr_idx]  <= illr;
      strb_buf[wr_half][wr_idx] <= istrb;
      run_min1 <= nxt_min1;
      run_min2 <= nxt_min2;
      run_idx  <= nxt_idx;
      run_par  <= nxt_par;
      // eof word included in the frozen set
      if (in_eof) begin
        dr_min1 <= nxt_min1;
        dr_min2 <= nxt_min2;
        dr_idx  <= nxt_idx;
        dr_par  <= nxt_par;
      end
    end
  end

  // pointers and drain control
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_cnt    <= '0;
      wr_half   <= 1'b0;
      rd_half   <= 1'b0;
      drain_act <= 1'b0;
      drain_cnt <= '0;
    end else if (iclkena) begin
      if (ival) begin
        wr_cnt <= wr_idx + 1'b1;
      end
      if (ival && in_eof) begin
        // swap halves, drain the one just filled
        wr_half   <= ~wr_half;
        rd_half   <= wr_half;
        drain_act <= 1'b1;
        drain_cnt <= '0;
      end else if (drain_act) begin
        drain_cnt <= drain_cnt + 1'b1;
        if (drain_cnt == idx_t'(pDEC_NUM-1)) begin
          drain_act <= 1'b0;
        end
      end
    end
  end

  //--------------------------------------------------
  // drain side, extrinsic and decision
  //--------------------------------------------------

  llr_t  dr_llr;
  logic  dr_sign, ex_sign;
  mag_t  ex_mag;
  logic signed [cSAT_W-1 : 0] ex_wide, llr_wide, sum_wide;
  extr_t ex_sat;

  always_comb begin
    dr_llr  = llr_buf[rd_half][drain_cnt];
    dr_sign = dr_llr[cLLR_W-1];
    // exclude own magnitude from the minimum
    ex_mag  = (drain_cnt == dr_idx) ? dr_min2 : dr_min1;
    // parity of the other signs
    ex_sign = dr_par ^ dr_sign;
    ex_wide = $signed({{(cSAT_W-cLLR_W){1'b0}}, ex_mag});
    if (ex_sign) begin
      ex_wide = -ex_wide;
    end
    if (ex_wide > cEXTR_MAX) begin
      ex_sat = extr_t'(cEXTR_MAX);
    end else if (ex_wide < cEXTR_MIN) begin
      ex_sat = extr_t'(cEXTR_MIN);
    end else begin
      ex_sat = extr_t'(ex_wide);
    end
    llr_wide = dr_llr;
    // zero sum decides bit 0
    sum_wide = llr_wide + cSAT_W'(ex_sat);
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= drain_act;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && drain_act) begin
      ostrb   <= strb_buf[rd_half][drain_cnt];
      oextr   <= ex_sat;
      obitdat <= sum_wide[cSAT_W-1];
      obiterr <= sum_wide[cSAT_W-1] ^ dr_sign;
    end
  end

endmodule

`default_nettype wire

/* comp_code/btc_dec_comp_code_asm.sv */
`timescale 1ns/1ps
`default_nettype none

module btc_dec_comp_code_asm import btc_dec_pkg::*; #(
  parameter int pDAT_W   = 6,
  parameter int pDEC_NUM = 8
) (
  input  wire logic                 iclk,
  input  wire logic                 ireset,
  input  wire logic                 iclkena,
  input  wire logic                 ival,
  input  wire strb_t                istrb,
  input  wire logic  [pDAT_W-1 : 0] idat,
  output logic                      oval,
  output strb_t                     ostrb,
  output logic       [pDAT_W-1 : 0] odat [pDEC_NUM]
);

  localparam int cIDX_W = (pDEC_NUM > 1) ? $clog2(pDEC_NUM) : 1;

  logic [cIDX_W-1 : 0] wr_cnt, wr_idx;

  //--------------------------------------------------
  // slot index
  //--------------------------------------------------

  // sof restarts the vector
  assign wr_idx = istrb[cSTRB_SOF] ? '0 : wr_cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_cnt <= '0;
      oval   <= 1'b0;
    end else if (iclkena) begin
      if (ival) begin
        wr_cnt <= wr_idx + 1'b1;
      end
      // one cycle pulse after the last word
      oval <= ival & istrb[cSTRB_EOF];
    end
  end

  //--------------------------------------------------
  // vector slots
  //--------------------------------------------------

  // next sof lands after the pulse, vector stays stable
  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      odat[wr_idx] <= idat;
      // keep the codeword's first strobe
      if (istrb[cSTRB_SOF]) begin
        ostrb <= istrb;
      end
    end
  end

endmodule

`default_nettype wire

/* comp_code/btc_dec_comp_code_sink.sv */
`timescale 1ns/1ps
`default_nettype none

module btc_dec_comp_code_sink import btc_dec_pkg::*; #(
  parameter int pERR_W   = 16,
  parameter int pDEC_NUM = 8
) (
  input  wire logic                   iclk,
  input  wire logic                   ireset,
  input  wire logic                   iclkena,
  input  wire logic                   irow_mode,
  input  wire logic  [pDEC_NUM-1 : 0] ival,
  input  wire strb_t                  istrb [pDEC_NUM],
  input  wire extr_t                  iextr [pDEC_NUM],
  input  wire logic  [pDEC_NUM-1 : 0] ibitdat,
  input  wire logic  [pDEC_NUM-1 : 0] ibiterr,
  output logic                        oval,
  output strb_t                       ostrb,
  output extr_t                       olextr [pDEC_NUM],
  output logic       [pDEC_NUM-1 : 0] obitdat,
  output logic       [pERR_W-1 : 0]   obiterr
);

  // extrinsic plus decision bit
  localparam int cASM_W = cEXTR_W + 1;

  logic [pDEC_NUM-1 : 0] asm_val;
  strb_t                 asm_strb [pDEC_NUM];
  logic [cASM_W-1 : 0]   asm_dat  [pDEC_NUM][pDEC_NUM];

  strb_t                 sel_strb;
  logic [cASM_W-1 : 0]   sel_dat  [pDEC_NUM];

  //--------------------------------------------------
  // per lane vector assemblers
  //--------------------------------------------------

  for (genvar g = 0; g < pDEC_NUM; g++) begin : gen_asm
    btc_dec_comp_code_asm #(
      .pDAT_W   (cASM_W),
      .pDEC_NUM (pDEC_NUM)
    ) asm_i (
      .iclk    (iclk),
      .ireset  (ireset),
      .iclkena (iclkena),
      .ival    (ival[g]),
      .istrb   (istrb[g]),
      .idat    ({ibitdat[g], iextr[g]}),
      .oval    (asm_val[g]),
      .ostrb   (asm_strb[g]),
      .odat    (asm_dat[g])
    );
  end

  // highest finished lane wins
  always_comb begin
    sel_strb = asm_strb[0];
    sel_dat  = asm_dat[0];
    for (int i = 1; i < pDEC_NUM; i++) begin
      if (asm_val[i]) begin
        sel_strb = asm_strb[i];
        sel_dat  = asm_dat[i];
      end
    end
  end

  //--------------------------------------------------
  // output mux
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      // row: any vector done, column: lockstep lane 0
      oval <= irow_mode ? (|asm_val) : ival[0];
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (irow_mode) begin
        ostrb <= sel_strb;
        for (int b = 0; b < pDEC_NUM; b++) begin
          {obitdat[b], olextr[b]} <= sel_dat[b];
        end
      end else begin
        // column bypass
        ostrb   <= istrb[0];
        olextr  <= iextr;
        obitdat <= ibitdat;
      end
    end
  end

  //--------------------------------------------------
  // frame bit error counter
  //--------------------------------------------------

  logic [pDEC_NUM-1 : 0] err_ok;

  always_comb begin
    for (int i = 0; i < pDEC_NUM; i++) begin
      err_ok[i] = ~istrb[i][cSTRB_MASK];
    end
  end

  function automatic logic [pERR_W-1 : 0] popcount(input logic [pDEC_NUM-1 : 0] v);
    logic [pERR_W-1 : 0] acc;
    acc = '0;
    for (int i = 0; i < pDEC_NUM; i++) begin
      acc = acc + v[i];
    end
    return acc;
  endfunction

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      obiterr <= '0;
    end else if (iclkena) begin
      // sof on lane 0 opens a new frame
      if (ival[0] && istrb[0][cSTRB_SOF]) begin
        obiterr <= popcount(ibiterr & ival);
      end else if (|ival) begin
        obiterr <= obiterr + popcount(ibiterr & ival & err_ok);
      end
    end
  end

endmodule

`default_nettype wire

/* source/btc_dec_comp_code_top.sv */
`timescale 1ns/1ps
`default_nettype none

module btc_dec_comp_code_top import btc_dec_pkg::*; #(
  parameter int pDEC_NUM = 8,
  parameter int pERR_W   = 16
) (
  input  wire logic                   iclk,
  input  wire logic                   ireset,
  input  wire logic                   iclkena,
  input  wire logic                   irow_mode,
  input  wire logic  [pDEC_NUM-1 : 0] ival,
  input  wire strb_t                  istrb [pDEC_NUM],
  input  wire llr_t                   illr  [pDEC_NUM],
  output logic                        oval,
  output strb_t                       ostrb,
  output extr_t                       olextr [pDEC_NUM],
  output logic       [pDEC_NUM-1 : 0] obitdat,
  output logic       [pERR_W-1 : 0]   obiterr
);

  //--------------------------------------------------
  // lane decoders
  //--------------------------------------------------

  logic [pDEC_NUM-1 : 0] lane_val;
  strb_t                 lane_strb [pDEC_NUM];
  extr_t                 lane_extr [pDEC_NUM];
  logic [pDEC_NUM-1 : 0] lane_bitdat;
  logic [pDEC_NUM-1 : 0] lane_biterr;

  // one codeword per lane
  for (genvar g = 0; g < pDEC_NUM; g++) begin : gen_lane
    btc_dec_comp_code_lane #(
      .pDEC_NUM (pDEC_NUM)
    ) lane_i (
      .iclk    (iclk),
      .ireset  (ireset),
      .iclkena (iclkena),
      .ival    (ival[g]),
      .istrb   (istrb[g]),
      .illr    (illr[g]),
      .oval    (lane_val[g]),
      .ostrb   (lane_strb[g]),
      .oextr   (lane_extr[g]),
      .obitdat (lane_bitdat[g]),
      .obiterr (lane_biterr[g])
    );
  end

  //--------------------------------------------------
  // sink, column bypass or row vectors
  //--------------------------------------------------

  btc_dec_comp_code_sink #(
    .pERR_W   (pERR_W),
    .pDEC_NUM (pDEC_NUM)
  ) sink_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .irow_mode (irow_mode),
    .ival      (lane_val),
    .istrb     (lane_strb),
    .iextr     (lane_extr),
    .ibitdat   (lane_bitdat),
    .ibiterr   (lane_biterr),
    .oval      (oval),
    .ostrb     (ostrb),
    .olextr    (olextr),
    .obitdat   (obitdat),
    .obiterr   (obiterr)
  );

endmodule

`default_nettype wire

/* dv/btc_dec_comp_code_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module btc_dec_comp_code_tb import btc_dec_pkg::*; ();

  localparam int cDEC_NUM = 8;
  localparam int cERR_W   = 16;
  // 6 tests of 200 cycles each
  localparam int cTIMEOUT = 6 * 200;
  localparam int cLAT     = 3;

  logic                  iclk;
  logic                  ireset;
  logic                  iclkena;
  logic                  irow_mode;
  logic [cDEC_NUM-1 : 0] ival;
  strb_t                 istrb  [cDEC_NUM];
  llr_t                  illr   [cDEC_NUM];
  logic                  oval;
  strb_t                 ostrb;
  extr_t                 olextr [cDEC_NUM];
  logic [cDEC_NUM-1 : 0] obitdat;
  logic [cERR_W-1 : 0]   obiterr;

  btc_dec_comp_code_top #(
    .pDEC_NUM (cDEC_NUM),
    .pERR_W   (cERR_W)
  ) dut_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .irow_mode (irow_mode),
    .ival      (ival),
    .istrb     (istrb),
    .illr      (illr),
    .oval      (oval),
    .ostrb     (ostrb),
    .olextr    (olextr),
    .obitdat   (obitdat),
    .obiterr   (obiterr)
  );

  //--------------------------------------------------
  // clock, cycle counters and timeout
  //--------------------------------------------------

  always #2 iclk = ~iclk;

  int   run_cyc = 0;
  int   en_cyc  = 0;
  int   eof_cyc = 0;
  logic en_last = 1'b0;

  always @(posedge iclk) begin
    run_cyc <= run_cyc + 1;
    en_last <= iclkena;
    if (iclkena) begin
      en_cyc <= en_cyc + 1;
      // lane 0 eof accepted here
      if (ival[0] && istrb[0][cSTRB_EOF]) begin
        eof_cyc <= en_cyc;
      end
    end
  end

  initial begin
    wait (run_cyc >= cTIMEOUT);
    $display("timeout, run did not finish within %0d cycles", cTIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //--------------------------------------------------
  // stimulus store and lfsr
  //--------------------------------------------------

  // indexed by lane then codeword then word
  llr_t llr_v [cDEC_NUM][2][cDEC_NUM];
  logic msk_v [cDEC_NUM][2][cDEC_NUM];

  logic [31 : 0] lfsr_state = 32'hea7b;

  function automatic logic next_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'hb4bc_d35c;
    end
    return b;
  endfunction

  function automatic logic [31 : 0] rand_bits(input int n);
    logic [31 : 0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | next_bit();
    end
    return v;
  endfunction

  // stall about one cycle in four
  function automatic logic pick_enable();
    logic [1 : 0] r;
    r = rand_bits(2);
    return ~&r;
  endfunction

  task automatic gen_data(input logic mask_en);
    for (int l = 0; l < cDEC_NUM; l++) begin
      for (int c = 0; c < 2; c++) begin
        for (int w = 0; w < cDEC_NUM; w++) begin
          llr_v[l][c][w] = llr_t'(rand_bits(cLLR_W));
          // filler never on the sof word
          msk_v[l][c][w] = (mask_en && w != 0) ? next_bit() : 1'b0;
        end
      end
    end
  endtask

  function automatic strb_t make_strb(input int l, input int c, input int w);
    strb_t s;
    s = '0;
    s[cSTRB_SOF]  = (w == 0);
    s[cSTRB_EOF]  = (w == cDEC_NUM-1);
    s[cSTRB_MASK] = msk_v[l][c][w];
    return s;
  endfunction

  //--------------------------------------------------
  // reference min-sum model
  //--------------------------------------------------

  function automatic void ref_word(input int l, input int c, input int k,
                                   output extr_t ex, output logic dec, output logic err);
    int mag, m, v, own;
    logic sgn;
    mag = 1000;
    sgn = 1'b0;
    for (int j = 0; j < cDEC_NUM; j++) begin
      if (j != k) begin
        v = llr_v[l][c][j];
        m = (v < 0) ? -v : v;
        if (m < mag) begin
          mag = m;
        end
        sgn = sgn ^ (v < 0);
      end
    end
    v = sgn ? -mag : mag;
    // saturate to the extrinsic range
    if (v > 2**(cEXTR_W-1) - 1) begin
      v = 2**(cEXTR_W-1) - 1;
    end else if (v < -(2**(cEXTR_W-1))) begin
      v = -(2**(cEXTR_W-1));
    end
    own = llr_v[l][c][k];
    ex  = extr_t'(v);
    dec = (own + v) < 0;
    err = dec != (own < 0);
  endfunction

  // count restarts on the last lane 0 sof
  function automatic int expected_errors(input int ncw);
    int sum;
    extr_t ex;
    logic dec, err;
    sum = 0;
    for (int l = 0; l < cDEC_NUM; l++) begin
      for (int w = 0; w < cDEC_NUM; w++) begin
        ref_word(l, ncw-1, w, ex, dec, err);
        if (err && !msk_v[l][ncw-1][w]) begin
          sum++;
        end
      end
    end
    return sum;
  endfunction

  function automatic int masked_errors();
    int sum;
    extr_t ex;
    logic dec, err;
    sum = 0;
    for (int l = 0; l < cDEC_NUM; l++) begin
      for (int w = 0; w < cDEC_NUM; w++) begin
        ref_word(l, 0, w, ex, dec, err);
        if (err && msk_v[l][0][w]) begin
          sum++;
        end
      end
    end
    return sum;
  endfunction

  //--------------------------------------------------
  // expected output events
  //--------------------------------------------------

  logic [cDEC_NUM*cEXTR_W-1 : 0] exp_ex_q   [$];
  logic [cDEC_NUM-1 : 0]         exp_bit_q  [$];
  strb_t                         exp_strb_q [$];

  // one parallel word per bit position in lockstep
  task automatic push_column(input int ncw);
    logic [cDEC_NUM*cEXTR_W-1 : 0] ex_p;
    logic [cDEC_NUM-1 : 0] bits;
    extr_t ex;
    logic err;
    for (int c = 0; c < ncw; c++) begin
      for (int w = 0; w < cDEC_NUM; w++) begin
        for (int l = 0; l < cDEC_NUM; l++) begin
          ref_word(l, c, w, ex, bits[l], err);
          ex_p[l*cEXTR_W +: cEXTR_W] = ex;
        end
        exp_ex_q.push_back(ex_p);
        exp_bit_q.push_back(bits);
        exp_strb_q.push_back(make_strb(0, c, w));
      end
    end
  endtask

  // one full codeword vector per staggered lane
  task automatic push_row();
    logic [cDEC_NUM*cEXTR_W-1 : 0] ex_p;
    logic [cDEC_NUM-1 : 0] bits;
    extr_t ex;
    logic err;
    for (int l = 0; l < cDEC_NUM; l++) begin
      for (int b = 0; b < cDEC_NUM; b++) begin
        ref_word(l, 0, b, ex, bits[b], err);
        ex_p[b*cEXTR_W +: cEXTR_W] = ex;
      end
      exp_ex_q.push_back(ex_p);
      exp_bit_q.push_back(bits);
      exp_strb_q.push_back(make_strb(l, 0, 0));
    end
  endtask

  //--------------------------------------------------
  // compare tasks
  //--------------------------------------------------

  int err_cnt  = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  task automatic check_extr(input string name, input extr_t got, input extr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bits(input string name, input logic [cDEC_NUM-1 : 0] got,
                            input logic [cDEC_NUM-1 : 0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_err(input string name, input logic [cERR_W-1 : 0] got,
                           input logic [cERR_W-1 : 0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  //--------------------------------------------------
  // output monitor sampled mid cycle
  //--------------------------------------------------

  logic chk_lat   = 1'b0;
  logic oval_prev = 1'b0;

  always @(negedge iclk) begin
    if (!ireset) begin
      if (!en_last && oval !== oval_prev) begin
        $display("oval changed while iclkena was low");
        err_cnt++;
      end
      if (en_last && oval === 1'b1) begin
        if (exp_strb_q.size() == 0) begin
          $display("output word seen with no result expected");
          err_cnt++;
        end else begin
          check_strb("ostrb", ostrb, exp_strb_q.pop_front());
          check_bits("obitdat", obitdat, exp_bit_q.pop_front());
          for (int b = 0; b < cDEC_NUM; b++) begin
            check_extr($sformatf("olextr[%0d]", b), olextr[b],
                       exp_ex_q[0][b*cEXTR_W +: cEXTR_W]);
          end
          void'(exp_ex_q.pop_front());
          if (chk_lat) begin
            chk_lat = 1'b0;
            if (en_cyc - eof_cyc != cLAT) begin
              $display("first output came %0d enabled cycles after eof, not %0d",
                       en_cyc - eof_cyc, cLAT);
              err_cnt++;
            end
          end
        end
      end
      oval_prev = oval;
    end
  end

  //--------------------------------------------------
  // drivers
  //--------------------------------------------------

  task automatic set_inputs(input int t, input int stagger, input int ncw);
    int pos;
    for (int l = 0; l < cDEC_NUM; l++) begin
      pos = t - stagger*l;
      if (pos >= 0 && pos < ncw*cDEC_NUM) begin
        ival[l]  = 1'b1;
        istrb[l] = make_strb(l, pos / cDEC_NUM, pos % cDEC_NUM);
        illr[l]  = llr_v[l][pos / cDEC_NUM][pos % cDEC_NUM];
      end else begin
        ival[l]  = 1'b0;
        istrb[l] = '0;
        illr[l]  = '0;
      end
    end
  endtask

  // lane l starts stagger*l words late
  task automatic drive_traffic(input int stagger, input int ncw, input logic stall);
    int total;
    total = stagger*(cDEC_NUM-1) + ncw*cDEC_NUM;
    for (int t = 0; t <= total; t++) begin
      do begin
        @(posedge iclk);
        #0.5;
        iclkena = stall ? pick_enable() : 1'b1;
        set_inputs(t, stagger, ncw);
      end while (!iclkena);
    end
  endtask

  // idle until all results are out plus a few spare cycles
  task automatic wait_drain(input logic stall);
    int idle;
    idle = 0;
    while (idle < cDEC_NUM + 4) begin
      @(posedge iclk);
      #0.5;
      iclkena = stall ? pick_enable() : 1'b1;
      if (exp_strb_q.size() == 0 && iclkena) begin
        idle++;
      end
    end
  endtask

  task automatic report_test(input string name, input int base);
    if (err_cnt == base) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: %0d errors", name, err_cnt - base);
    end
  endtask

  //--------------------------------------------------
  // directed tests
  //--------------------------------------------------

  task automatic test_column_single(input logic stall, input string name);
    int base;
    base = err_cnt;
    irow_mode = 1'b0;
    gen_data(1'b0);
    push_column(1);
    chk_lat = 1'b1;
    drive_traffic(0, 1, stall);
    wait_drain(stall);
    check_err("obiterr", obiterr, cERR_W'(expected_errors(1)));
    report_test(name, base);
  endtask

  task automatic test_column_back_to_back();
    int base;
    base = err_cnt;
    irow_mode = 1'b0;
    gen_data(1'b0);
    push_column(2);
    drive_traffic(0, 2, 1'b0);
    wait_drain(1'b0);
    check_err("obiterr", obiterr, cERR_W'(expected_errors(2)));
    report_test("test 2 column back-to-back", base);
  endtask

  // one frame with lane l one cycle after lane l-1
  task automatic row_frame(input logic mask_en);
    irow_mode = 1'b1;
    gen_data(mask_en);
    push_row();
    drive_traffic(1, 1, 1'b0);
    wait_drain(1'b0);
    check_err("obiterr", obiterr, cERR_W'(expected_errors(1)));
  endtask

  task automatic test_row_stagger();
    int base;
    base = err_cnt;
    row_frame(1'b0);
    report_test("test 3 row staggered", base);
  endtask

  task automatic test_frame_count();
    int base;
    base = err_cnt;
    row_frame(1'b0);
    // second frame must not carry over the first count
    row_frame(1'b0);
    report_test("test 4 frame error count", base);
  endtask

  task automatic test_mask();
    int base;
    base = err_cnt;
    row_frame(1'b1);
    if (masked_errors() == 0) begin
      $display("no masked word carried an error flag");
      err_cnt++;
    end
    report_test($sformatf("test 5 mask, %0d masked errors", masked_errors()), base);
  endtask

  initial begin
    iclk      = 1'b0;
    ireset    = 1'b1;
    iclkena   = 1'b0;
    irow_mode = 1'b0;
    ival      = '0;
    for (int l = 0; l < cDEC_NUM; l++) begin
      istrb[l] = '0;
      illr[l]  = '0;
    end
    repeat (8) @(posedge iclk);
    #0.5;
    ireset  = 1'b0;
    iclkena = 1'b1;

    test_column_single(1'b0, "test 1 column single codeword");
    test_column_back_to_back();
    test_row_stagger();
    test_frame_count();
    test_mask();
    test_column_single(1'b1, "test 6 clock enable stall");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
common/btc_dec_pkg.sv
comp_code/btc_dec_comp_code_lane.sv
comp_code/btc_dec_comp_code_asm.sv
comp_code/btc_dec_comp_code_sink.sv
source/btc_dec_comp_code_top.sv
dv/btc_dec_comp_code_tb.sv

/* Bender.yml */
package:
  name: btc_dec_comp_code

sources:
  # shared package first
  - common/btc_dec_pkg.sv
  # component code lane, assembler and sink
  - comp_code/btc_dec_comp_code_lane.sv
  - comp_code/btc_dec_comp_code_asm.sv
  - comp_code/btc_dec_comp_code_sink.sv
  # top level
  - source/btc_dec_comp_code_top.sv
  # testbench
  - target: test
    files:
      - dv/btc_dec_comp_code_tb.sv
